//--- hw/maze_pkg.sv
package maze_pkg;

    // Play field
    localparam int grid_rows = 15;
    localparam int grid_cols = 20;
    localparam int row_w     = 4;
    localparam int col_w     = 5;

    // Cell codes, 2 and 3 are reserved and act as walls
    localparam int cell_w = 2;
    localparam logic [cell_w-1:0] cell_free = 2'd0;
    localparam logic [cell_w-1:0] cell_wall = 2'd1;

    localparam int level_w = 4;

    // Up lowers the row, right raises the column
    typedef enum logic [1:0] {
        dir_up,
        dir_right,
        dir_down,
        dir_left
    } dir_t;

    localparam int sprite_count = 4;
    localparam int sprite_w     = 2;

    typedef logic [0:grid_rows-1][0:grid_cols-1][cell_w-1:0] cell_map_t;

    // Spawn cells, index 0 on the right
    localparam logic [sprite_count-1:0][row_w-1:0] spawn_row = {
        4'd13,
        4'd13,
        4'd1,
        4'd1
    };

    localparam logic [sprite_count-1:0][col_w-1:0] spawn_col = {
        5'd18,
        5'd1,
        5'd18,
        5'd1
    };

endpackage

//--- hw/barrier_map.sv
module barrier_map (
    input  logic [maze_pkg::level_w-1:0] level_sel,
    output maze_pkg::cell_map_t          cell_map
);

    // One bit per cell, column 0 is the leftmost bit of each row
    logic [0:maze_pkg::grid_rows-1][maze_pkg::grid_cols-1:0] wall_rows;

    always_comb begin
        case (level_sel)
            // Lettered sign
            4'd1: wall_rows = {
                20'b00000_00000_00000_00000,
                20'b00000_00000_00000_00000,
                20'b00000_00000_00000_00000,
                20'b00000_00000_00000_00000,
                20'b00000_00000_00000_00000,
                20'b00001_11011_10011_10000,
                20'b00001_00010_00010_00000,
                20'b00001_10010_00011_00000,
                20'b00001_00010_00010_00000,
                20'b00001_11011_10011_10000,
                20'b00000_00000_00000_00000,
                20'b00000_00000_00000_00000,
                20'b00000_00000_00000_00000,
                20'b00000_00000_00000_00000,
                20'b00000_00000_00000_00000
            };
            // Numbered sign
            4'd2: wall_rows = {
                20'b00000_00000_00000_00000,
                20'b00000_00000_00000_00000,
                20'b00000_00000_00000_00000,
                20'b00000_00000_00000_00000,
                20'b00000_00000_00000_00000,
                20'b00011_10000_00011_10000,
                20'b00000_10000_00010_00000,
                20'b00001_10000_00011_10000,
                20'b00000_10011_11000_10000,
                20'b00011_10010_01011_10000,
                20'b00000_00011_11000_00000,
                20'b00000_00010_01000_00000,
                20'b00000_00010_01000_00000,
                20'b00000_00011_11000_00000,
                20'b00000_00000_00000_00000
            };
            // Post with a bar across row 9
            4'd3: wall_rows = {
                20'b00000_00000_00000_00000,
                20'b00000_00000_00000_00000,
                20'b00000_00000_00000_00000,
                20'b00000_00001_10000_00000,
                20'b00000_00001_10000_00000,
                20'b00000_00001_10000_00000,
                20'b00000_00000_00000_00000,
                20'b00000_00000_00000_00000,
                20'b00000_00000_00000_00000,
                20'b00001_11111_11111_10000,
                20'b00000_00000_00000_00000,
                20'b00000_00000_00000_00000,
                20'b00000_00000_00000_00000,
                20'b00000_00000_00000_00000,
                20'b00000_00000_00000_00000
            };
            // Face
            4'd4: wall_rows = {
                20'b00000_00000_00000_00000,
                20'b00000_00000_00000_00000,
                20'b00000_00000_00000_00000,
                20'b00000_00000_00000_00000,
                20'b00000_00000_00000_00000,
                20'b00000_00110_01100_00000,
                20'b00000_00110_01100_00000,
                20'b00000_00000_00000_00000,
                20'b00000_01000_00010_00000,
                20'b00000_00100_00100_00000,
                20'b00000_00011_11000_00000,
                20'b00000_00000_00000_00000,
                20'b00000_00000_00000_00000,
                20'b00000_00000_00000_00000,
                20'b00000_00000_00000_00000
            };
            default: wall_rows = '0;
        endcase
    end

    // Expand the wall bits into cell codes
    always_comb begin
        for (int r = 0; r < maze_pkg::grid_rows; r++) begin
            for (int c = 0; c < maze_pkg::grid_cols; c++) begin
                if (wall_rows[r][maze_pkg::grid_cols-1-c]) begin
                    cell_map[r][c] = maze_pkg::cell_wall;
                end else begin
                    cell_map[r][c] = maze_pkg::cell_free;
                end
            end
        end
    end

endmodule

//--- hw/move_if.sv
interface move_if;

    // Tracker side
    logic                       check_start;
    logic [maze_pkg::row_w-1:0] cur_row;
    logic [maze_pkg::col_w-1:0] cur_col;
    maze_pkg::dir_t             dir;
    // Cells held by the sprites that are not moving
    logic [0:maze_pkg::grid_rows-1][0:maze_pkg::grid_cols-1] others_occ;

    // Checker side
    logic                       check_done;
    logic [maze_pkg::row_w-1:0] tgt_row;
    logic [maze_pkg::col_w-1:0] tgt_col;
    logic                       blocked;

    modport tracker (
        output check_start, cur_row, cur_col, dir, others_occ,
        input  check_done, tgt_row, tgt_col, blocked
    );

    modport check (
        input  check_start, cur_row, cur_col, dir, others_occ,
        output check_done, tgt_row, tgt_col, blocked
    );

endinterface

//--- hw/collision_check.sv
module collision_check (
    input  logic                clk,
    input  logic                rst_n,
    move_if.check               chk,
    input  maze_pkg::cell_map_t cell_map
);

    logic [maze_pkg::row_w-1:0] nxt_row;
    logic [maze_pkg::col_w-1:0] nxt_col;
    logic                       off_grid;
    logic                       hit;

    // Neighbor cell, stays on the current cell when the step leaves the grid
    always_comb begin
        nxt_row  = chk.cur_row;
        nxt_col  = chk.cur_col;
        off_grid = 1'b0;
        case (chk.dir)
            maze_pkg::dir_up: begin
                if (chk.cur_row == '0) begin
                    off_grid = 1'b1;
                end else begin
                    nxt_row = chk.cur_row - 1'b1;
                end
            end
            maze_pkg::dir_right: begin
                if (chk.cur_col == maze_pkg::col_w'(maze_pkg::grid_cols - 1)) begin
                    off_grid = 1'b1;
                end else begin
                    nxt_col = chk.cur_col + 1'b1;
                end
            end
            maze_pkg::dir_down: begin
                if (chk.cur_row == maze_pkg::row_w'(maze_pkg::grid_rows - 1)) begin
                    off_grid = 1'b1;
                end else begin
                    nxt_row = chk.cur_row + 1'b1;
                end
            end
            default: begin
                if (chk.cur_col == '0) begin
                    off_grid = 1'b1;
                end else begin
                    nxt_col = chk.cur_col - 1'b1;
                end
            end
        endcase
    end

    // Any non-free code counts as a wall
    assign hit = (cell_map[nxt_row][nxt_col] != maze_pkg::cell_free) ||
                 chk.others_occ[nxt_row][nxt_col];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            chk.check_done <= 1'b0;
            chk.blocked    <= 1'b0;
        end else begin
            chk.check_done <= chk.check_start;
            if (chk.check_start) begin
                chk.blocked <= off_grid || hit;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (chk.check_start) begin
            chk.tgt_row <= nxt_row;
            chk.tgt_col <= nxt_col;
        end
    end

endmodule

//--- hw/sprite_tracker.sv
module sprite_tracker (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          level_valid,
    input  logic [maze_pkg::level_w-1:0]  level_sel,
    output logic                          level_ready,
    input  logic                          move_valid,
    input  logic [maze_pkg::sprite_w-1:0] move_sprite,
    input  maze_pkg::dir_t                move_dir,
    output logic                          move_ready,
    output logic                          resp_valid,
    input  logic                          resp_ready,
    output logic [maze_pkg::sprite_w-1:0] resp_sprite,
    output logic [maze_pkg::row_w-1:0]    resp_row,
    output logic [maze_pkg::col_w-1:0]    resp_col,
    output logic                          resp_blocked,
    output logic [maze_pkg::level_w-1:0]  cur_level,
    input  maze_pkg::cell_map_t           cell_map
);

    typedef enum logic [1:0] {
        st_idle,
        st_check,
        st_resp
    } state_t;

    state_t                                                  state;
    logic [maze_pkg::sprite_count-1:0][maze_pkg::row_w-1:0] pos_row;
    logic [maze_pkg::sprite_count-1:0][maze_pkg::col_w-1:0] pos_col;
    logic [maze_pkg::sprite_w-1:0]                          sel;
    maze_pkg::dir_t                                          dir_q;
    logic [maze_pkg::level_w-1:0]                           level_q;
    logic                                                    level_acc;
    logic                                                    move_acc;

    move_if mv ();

    collision_check i_check (
        .clk      (clk),
        .rst_n    (rst_n),
        .chk      (mv.check),
        .cell_map (cell_map)
    );

    // A pending level load wins over a move in the same cycle
    assign level_ready = (state == st_idle);
    assign move_ready  = (state == st_idle) && !level_valid;
    assign level_acc   = level_valid && level_ready;
    assign move_acc    = move_valid && move_ready;
    assign cur_level   = level_q;

    assign mv.cur_row = pos_row[sel];
    assign mv.cur_col = pos_col[sel];
    assign mv.dir     = dir_q;

    // Mark every sprite except the mover
    always_comb begin
        mv.others_occ = '0;
        for (int s = 0; s < maze_pkg::sprite_count; s++) begin
            if (maze_pkg::sprite_w'(s) != sel) begin
                mv.others_occ[pos_row[s]][pos_col[s]] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state          <= st_idle;
            level_q        <= '0;
            pos_row        <= maze_pkg::spawn_row;
            pos_col        <= maze_pkg::spawn_col;
            mv.check_start <= 1'b0;
            resp_valid     <= 1'b0;
        end else begin
            mv.check_start <= move_acc;
            case (state)
                st_idle: begin
                    if (level_acc) begin
                        level_q <= level_sel;
                        pos_row <= maze_pkg::spawn_row;
                        pos_col <= maze_pkg::spawn_col;
                    end else if (move_acc) begin
                        state <= st_check;
                    end
                end
                st_check: begin
                    if (mv.check_done) begin
                        if (!mv.blocked) begin
                            pos_row[sel] <= mv.tgt_row;
                            pos_col[sel] <= mv.tgt_col;
                        end
                        resp_valid <= 1'b1;
                        state      <= st_resp;
                    end
                end
                st_resp: begin
                    if (resp_ready) begin
                        resp_valid <= 1'b0;
                        state      <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Request and response payload
    always_ff @(posedge clk) begin
        if (move_acc) begin
            sel   <= move_sprite;
            dir_q <= move_dir;
        end
        if (state == st_check && mv.check_done) begin
            resp_sprite  <= sel;
            resp_blocked <= mv.blocked;
            // Blocked moves report the cell the sprite stays on
            resp_row     <= mv.blocked ? pos_row[sel] : mv.tgt_row;
            resp_col     <= mv.blocked ? pos_col[sel] : mv.tgt_col;
        end
    end

endmodule

//--- hw/maze_top.sv
module maze_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          level_valid,
    input  logic [maze_pkg::level_w-1:0]  level_sel,
    output logic                          level_ready,
    input  logic                          move_valid,
    input  logic [maze_pkg::sprite_w-1:0] move_sprite,
    input  maze_pkg::dir_t                move_dir,
    output logic                          move_ready,
    output logic                          resp_valid,
    input  logic                          resp_ready,
    output logic [maze_pkg::sprite_w-1:0] resp_sprite,
    output logic [maze_pkg::row_w-1:0]    resp_row,
    output logic [maze_pkg::col_w-1:0]    resp_col,
    output logic                          resp_blocked
);

    logic [maze_pkg::level_w-1:0] cur_level;
    maze_pkg::cell_map_t          cell_map;

    sprite_tracker i_tracker (
        .clk          (clk),
        .rst_n        (rst_n),
        .level_valid  (level_valid),
        .level_sel    (level_sel),
        .level_ready  (level_ready),
        .move_valid   (move_valid),
        .move_sprite  (move_sprite),
        .move_dir     (move_dir),
        .move_ready   (move_ready),
        .resp_valid   (resp_valid),
        .resp_ready   (resp_ready),
        .resp_sprite  (resp_sprite),
        .resp_row     (resp_row),
        .resp_col     (resp_col),
        .resp_blocked (resp_blocked),
        .cur_level    (cur_level),
        .cell_map     (cell_map)
    );

    // Map follows the registered level
    barrier_map i_map (
        .level_sel (cur_level),
        .cell_map  (cell_map)
    );

endmodule

//--- sim/clk_gen.sv
module clk_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    // Reset held low for two rising edges
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #2 rst_n = 1'b1;
    end

endmodule

//--- sim/maze_checker.sv
module maze_checker (
    input logic                          clk,
    input logic                          rst_n,
    input logic                          level_valid,
    input logic                          level_ready,
    input logic                          move_valid,
    input logic                          move_ready,
    input logic                          resp_valid,
    input logic                          resp_ready,
    input logic [maze_pkg::sprite_w-1:0] resp_sprite,
    input logic [maze_pkg::row_w-1:0]    resp_row,
    input logic [maze_pkg::col_w-1:0]    resp_col,
    input logic                          resp_blocked
);

    typedef struct {
        string name;
        int    sprite;
        int    row;
        int    col;
        bit    blk;
    } expect_t;

    expect_t exp_q[$];
    int      value_errors    = 0;
    int      protocol_errors = 0;
    int      cyc             = 0;
    int      acc_cyc         = -100;
    bit      prev_valid      = 1'b0;
    bit      hold            = 1'b0;
    logic [11:0] held;

    function void expect_move(string name, int sprite, int row, int col, bit blk);
        expect_t e;
        e.name   = name;
        e.sprite = sprite;
        e.row    = row;
        e.col    = col;
        e.blk    = blk;
        exp_q.push_back(e);
    endfunction

    task automatic compare_value(string test, string field, int exp_v, int act_v);
        if (exp_v != act_v) begin
            $display("CHECK FAILED %s %s: expected %0d, actual %0d", test, field, exp_v, act_v);
            value_errors++;
        end
    endtask

    always @(posedge clk) begin
        expect_t e;
        cyc++;
        if (!rst_n) begin
            prev_valid = 1'b0;
            hold       = 1'b0;
        end else begin
            if (move_valid && move_ready) begin
                if (resp_valid) begin
                    $display("Error: a request was accepted while a response was waiting");
                    protocol_errors++;
                end
                acc_cyc = cyc;
            end
            if (level_valid && level_ready && resp_valid) begin
                $display("Error: a level load was accepted while a response was waiting");
                protocol_errors++;
            end
            // Seen high one edge after it was set, so three samples after acceptance
            if (resp_valid && !prev_valid && (cyc - acc_cyc) != 3) begin
                $display("Error: resp_valid rose %0d cycles after acceptance, not 2",
                         cyc - acc_cyc - 1);
                protocol_errors++;
            end
            if (hold && (!resp_valid ||
                held != {resp_sprite, resp_row, resp_col, resp_blocked})) begin
                $display("Error: the response changed before it was taken");
                protocol_errors++;
            end
            hold = resp_valid && !resp_ready;
            held = {resp_sprite, resp_row, resp_col, resp_blocked};
            if (resp_valid && resp_ready) begin
                if (exp_q.size() == 0) begin
                    $display("Error: a response came with no move expecting one");
                    protocol_errors++;
                end else begin
                    e = exp_q.pop_front();
                    compare_value(e.name, "sprite", e.sprite, resp_sprite);
                    compare_value(e.name, "row", e.row, resp_row);
                    compare_value(e.name, "col", e.col, resp_col);
                    compare_value(e.name, "blocked", e.blk, resp_blocked);
                end
            end
            prev_valid = resp_valid;
        end
    end

endmodule

//--- sim/tb_maze_top.sv
module tb_maze_top;

    typedef struct {
        string          name;
        bit             is_load;
        int             level;
        int             sprite;
        maze_pkg::dir_t dir;
        int             row;
        int             col;
        bit             blk;
    } step_t;

    logic                          clk;
    logic                          rst_n;
    logic                          level_valid;
    logic [maze_pkg::level_w-1:0]  level_sel;
    logic                          level_ready;
    logic                          move_valid;
    logic [maze_pkg::sprite_w-1:0] move_sprite;
    maze_pkg::dir_t                move_dir;
    logic                          move_ready;
    logic                          resp_valid;
    logic                          resp_ready;
    logic [maze_pkg::sprite_w-1:0] resp_sprite;
    logic [maze_pkg::row_w-1:0]    resp_row;
    logic [maze_pkg::col_w-1:0]    resp_col;
    logic                          resp_blocked;

    step_t table_q[$];
    int    cycles = 0;
    int    limit  = 0;

    clk_gen i_clk (.clk(clk), .rst_n(rst_n));

    maze_top i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .level_valid  (level_valid),
        .level_sel    (level_sel),
        .level_ready  (level_ready),
        .move_valid   (move_valid),
        .move_sprite  (move_sprite),
        .move_dir     (move_dir),
        .move_ready   (move_ready),
        .resp_valid   (resp_valid),
        .resp_ready   (resp_ready),
        .resp_sprite  (resp_sprite),
        .resp_row     (resp_row),
        .resp_col     (resp_col),
        .resp_blocked (resp_blocked)
    );

    maze_checker i_chk (
        .clk          (clk),
        .rst_n        (rst_n),
        .level_valid  (level_valid),
        .level_ready  (level_ready),
        .move_valid   (move_valid),
        .move_ready   (move_ready),
        .resp_valid   (resp_valid),
        .resp_ready   (resp_ready),
        .resp_sprite  (resp_sprite),
        .resp_row     (resp_row),
        .resp_col     (resp_col),
        .resp_blocked (resp_blocked)
    );

    function void add_move(string n, int s, maze_pkg::dir_t d, int r, int c, bit b);
        step_t t;
        t.name    = n;
        t.is_load = 1'b0;
        t.level   = 0;
        t.sprite  = s;
        t.dir     = d;
        t.row     = r;
        t.col     = c;
        t.blk     = b;
        table_q.push_back(t);
    endfunction

    function void add_load(string n, int lvl);
        step_t t;
        t.name    = n;
        t.is_load = 1'b1;
        t.level   = lvl;
        t.sprite  = 0;
        t.dir     = maze_pkg::dir_up;
        t.row     = 0;
        t.col     = 0;
        t.blk     = 1'b0;
        table_q.push_back(t);
    endfunction

    // Expected cells worked out by hand from the level maps
    function void build_table();
        add_move("l0_s0_left", 0, maze_pkg::dir_left, 1, 0, 1'b0);
        add_move("l0_s0_left_edge", 0, maze_pkg::dir_left, 1, 0, 1'b1);
        add_move("l0_s0_right_c1", 0, maze_pkg::dir_right, 1, 1, 1'b0);
        add_move("l0_s0_right_c2", 0, maze_pkg::dir_right, 1, 2, 1'b0);
        add_move("l0_s0_right_c3", 0, maze_pkg::dir_right, 1, 3, 1'b0);
        add_move("l0_s0_right_c4", 0, maze_pkg::dir_right, 1, 4, 1'b0);
        add_move("l0_s2_right_c2", 2, maze_pkg::dir_right, 13, 2, 1'b0);
        add_move("l0_s2_right_c3", 2, maze_pkg::dir_right, 13, 3, 1'b0);
        add_move("l0_s2_right_c4", 2, maze_pkg::dir_right, 13, 4, 1'b0);
        for (int r = 12; r >= 2; r--) begin
            add_move($sformatf("l0_s2_up_r%0d", r), 2, maze_pkg::dir_up, r, 4, 1'b0);
        end
        add_move("l0_s2_up_onto_s0", 2, maze_pkg::dir_up, 2, 4, 1'b1);
        add_move("l0_s0_step_away", 0, maze_pkg::dir_right, 1, 5, 1'b0);
        add_move("l0_s2_up_freed", 2, maze_pkg::dir_up, 1, 4, 1'b0);
        add_move("l0_s0_up", 0, maze_pkg::dir_up, 0, 5, 1'b0);
        add_move("l0_s0_up_edge", 0, maze_pkg::dir_up, 0, 5, 1'b1);
        add_move("l0_s1_right", 1, maze_pkg::dir_right, 1, 19, 1'b0);
        add_move("l0_s1_right_edge", 1, maze_pkg::dir_right, 1, 19, 1'b1);
        add_move("l0_s3_down", 3, maze_pkg::dir_down, 14, 18, 1'b0);
        add_move("l0_s3_down_edge", 3, maze_pkg::dir_down, 14, 18, 1'b1);
        add_load("load_level3", 3);
        add_move("l3_s2_right_c2", 2, maze_pkg::dir_right, 13, 2, 1'b0);
        add_move("l3_s2_right_c3", 2, maze_pkg::dir_right, 13, 3, 1'b0);
        add_move("l3_s2_right_c4", 2, maze_pkg::dir_right, 13, 4, 1'b0);
        add_move("l3_s2_up_r12", 2, maze_pkg::dir_up, 12, 4, 1'b0);
        add_move("l3_s2_up_r11", 2, maze_pkg::dir_up, 11, 4, 1'b0);
        add_move("l3_s2_up_r10", 2, maze_pkg::dir_up, 10, 4, 1'b0);
        add_move("l3_s2_up_bar", 2, maze_pkg::dir_up, 10, 4, 1'b1);
        add_load("load_level1", 1);
        add_move("l1_s2_up_spawn", 2, maze_pkg::dir_up, 12, 1, 1'b0);
        add_move("l1_s2_right_c2", 2, maze_pkg::dir_right, 12, 2, 1'b0);
        add_move("l1_s2_right_c3", 2, maze_pkg::dir_right, 12, 3, 1'b0);
        add_move("l1_s2_right_c4", 2, maze_pkg::dir_right, 12, 4, 1'b0);
        add_move("l1_s2_up_r11", 2, maze_pkg::dir_up, 11, 4, 1'b0);
        add_move("l1_s2_up_r10", 2, maze_pkg::dir_up, 10, 4, 1'b0);
        add_move("l1_s2_up_stroke", 2, maze_pkg::dir_up, 10, 4, 1'b1);
    endfunction

    // Random back-pressure on the response port
    initial begin
        void'($urandom(42334));
        forever begin
            @(posedge clk);
            #2;
            if (rst_n) begin
                resp_ready = ($urandom % 3) != 0;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles >= limit) begin
            $display("Timeout after %0d cycles, the DUT stopped responding", cycles);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin
        step_t step;
        int    total;
        level_valid = 1'b0;
        level_sel   = '0;
        move_valid  = 1'b0;
        move_sprite = '0;
        move_dir    = maze_pkg::dir_up;
        resp_ready  = 1'b1;
        build_table();
        limit = table_q.size() * 20 + 50;
        wait (rst_n === 1'b1);
        for (int i = 0; i < table_q.size(); i++) begin
            step = table_q[i];
            @(posedge clk);
            #2;
            if (step.is_load) begin
                level_sel   = maze_pkg::level_w'(step.level);
                level_valid = 1'b1;
            end else begin
                move_sprite = maze_pkg::sprite_w'(step.sprite);
                move_dir    = step.dir;
                move_valid  = 1'b1;
                i_chk.expect_move(step.name, step.sprite, step.row, step.col, step.blk);
            end
            do begin
                @(posedge clk);
            end while (!(step.is_load ? level_ready : move_ready));
            #2;
            level_valid = 1'b0;
            move_valid  = 1'b0;
        end
        // Drain the last response
        while (i_chk.exp_q.size() != 0 || resp_valid) begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);
        total = i_chk.value_errors + i_chk.protocol_errors;
        $display("Value errors: %0d, protocol errors: %0d", i_chk.value_errors,
                 i_chk.protocol_errors);
        if (total == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- src.f
hw/maze_pkg.sv
hw/barrier_map.sv
hw/move_if.sv
hw/collision_check.sv
hw/sprite_tracker.sv
hw/maze_top.sv
sim/clk_gen.sv
sim/maze_checker.sv
sim/tb_maze_top.sv

//--- Bender.yml
package:
  name: maze_core

sources:
  - files:
      - hw/maze_pkg.sv
      - hw/barrier_map.sv
      - hw/move_if.sv
      - hw/collision_check.sv
      - hw/sprite_tracker.sv
      - hw/maze_top.sv
  - target: simulation
    files:
      - sim/clk_gen.sv
      - sim/maze_checker.sv
      - sim/tb_maze_top.sv
